// ==== hw/soc_mem_pkg.sv ====
// Address map, widths and shared types of the on-chip memory subsystem
// Region bases must be aligned to their region size
package soc_mem_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;

    localparam logic [ADDR_W-1:0] BOOT_BASE = 32'h0000_0000;
    localparam int BOOT_ADDR_W = 12;        // 4 KiB of byte offset
    localparam int BOOT_WORDS = 1024;
    localparam string BOOT_IMAGE_FILE = "hw/boot_image.hex";  // Relative to the project root

    localparam logic [ADDR_W-1:0] SYSCTRL_BASE = 32'h1000_0000;
    localparam int SYSCTRL_ADDR_W = 4;      // Four 32-bit registers
    localparam logic [DATA_W-1:0] SYSCTRL_ID = 32'h5EC0_0001;

    // Encodings follow the AXI response field
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } axil_resp_e;

    typedef enum logic [1:0] {
        TGT_BOOT,
        TGT_SYSCTRL,
        TGT_NONE
    } target_e;

    typedef enum logic [1:0] {
        DEC_IDLE,
        DEC_BUSY,
        DEC_RESP
    } dec_state_e;

endpackage

// ==== hw/axil_boot_mem.sv ====
// Boot memory preloaded from the hex image; every access answers OKAY
// One write and one read may be in flight; unaligned reads shift right with zero fill
`timescale 1ns/1ps

module axil_boot_mem (
    input  logic                                aclk,
    input  logic                                aresetn,
    input  logic [soc_mem_pkg::BOOT_ADDR_W-1:0] awaddr,
    input  logic                                awvalid,
    output logic                                awready,
    input  logic [soc_mem_pkg::DATA_W-1:0]      wdata,
    input  logic [soc_mem_pkg::STRB_W-1:0]      wstrb,
    input  logic                                wvalid,
    output logic                                wready,
    output soc_mem_pkg::axil_resp_e             bresp,
    output logic                                bvalid,
    input  logic                                bready,
    input  logic [soc_mem_pkg::BOOT_ADDR_W-1:0] araddr,
    input  logic                                arvalid,
    output logic                                arready,
    output logic [soc_mem_pkg::DATA_W-1:0]      rdata,
    output soc_mem_pkg::axil_resp_e             rresp,
    output logic                                rvalid,
    input  logic                                rready
);
    import soc_mem_pkg::*;

    logic [DATA_W-1:0] mem [BOOT_WORDS];
    logic [BOOT_ADDR_W-1:0] aw_addr_q;
    logic [DATA_W-1:0] w_data_q;
    logic [STRB_W-1:0] w_strb_q;
    logic aw_held;
    logic w_held;
    logic live;       // Rises on the first clock after reset and enables the readies
    logic do_write;

    initial $readmemh(BOOT_IMAGE_FILE, mem);

    assign awready = live && !aw_held;   // Address and data stay held until B completes
    assign wready = live && !w_held;
    assign arready = live && !rvalid;
    assign bresp = RESP_OKAY;
    assign rresp = RESP_OKAY;
    assign do_write = aw_held && w_held && !bvalid;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            live <= 1'b0;
            aw_held <= 1'b0;
            w_held <= 1'b0;
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            live <= 1'b1;
            if (awvalid && awready) begin
                aw_held <= 1'b1;
            end
            if (wvalid && wready) begin
                w_held <= 1'b1;
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
                aw_held <= 1'b0;
                w_held <= 1'b0;
            end else if (do_write) begin
                bvalid <= 1'b1;
            end
            if (arvalid && arready) begin
                rvalid <= 1'b1;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (awvalid && awready) begin
            aw_addr_q <= awaddr;
        end
        if (wvalid && wready) begin
            w_data_q <= wdata;
            w_strb_q <= wstrb;
        end
        if (do_write) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (w_strb_q[b]) begin
                    mem[aw_addr_q[BOOT_ADDR_W-1:2]][8*b +: 8] <= w_data_q[8*b +: 8];
                end
            end
        end
        // Byte offset moves the addressed byte down to lane 0
        if (arvalid && arready) begin
            rdata <= mem[araddr[BOOT_ADDR_W-1:2]] >> {araddr[1:0], 3'b000};
        end
    end

    assert property (@(posedge aclk) disable iff (!aresetn)
        rvalid && !rready |=> rvalid && $stable(rdata));

    assert property (@(posedge aclk) disable iff (!aresetn)
        bvalid && !bready |=> bvalid && $stable(bresp));

endmodule

// ==== hw/axil_addr_decoder.sv ====
// Routes one AXI-Lite master to the boot memory and the register block by address
// One transaction per direction at a time; unmapped addresses answer DECERR here
`timescale 1ns/1ps

module axil_addr_decoder (
    input  logic                                   aclk,
    input  logic                                   aresetn,
    input  logic [soc_mem_pkg::ADDR_W-1:0]         s_axil_awaddr,
    input  logic                                   s_axil_awvalid,
    output logic                                   s_axil_awready,
    input  logic [soc_mem_pkg::DATA_W-1:0]         s_axil_wdata,
    input  logic [soc_mem_pkg::STRB_W-1:0]         s_axil_wstrb,
    input  logic                                   s_axil_wvalid,
    output logic                                   s_axil_wready,
    output soc_mem_pkg::axil_resp_e                s_axil_bresp,
    output logic                                   s_axil_bvalid,
    input  logic                                   s_axil_bready,
    input  logic [soc_mem_pkg::ADDR_W-1:0]         s_axil_araddr,
    input  logic                                   s_axil_arvalid,
    output logic                                   s_axil_arready,
    output logic [soc_mem_pkg::DATA_W-1:0]         s_axil_rdata,
    output soc_mem_pkg::axil_resp_e                s_axil_rresp,
    output logic                                   s_axil_rvalid,
    input  logic                                   s_axil_rready,
    output logic [soc_mem_pkg::BOOT_ADDR_W-1:0]    boot_awaddr,
    output logic                                   boot_awvalid,
    input  logic                                   boot_awready,
    output logic [soc_mem_pkg::DATA_W-1:0]         boot_wdata,
    output logic [soc_mem_pkg::STRB_W-1:0]         boot_wstrb,
    output logic                                   boot_wvalid,
    input  logic                                   boot_wready,
    input  soc_mem_pkg::axil_resp_e                boot_bresp,
    input  logic                                   boot_bvalid,
    output logic                                   boot_bready,
    output logic [soc_mem_pkg::BOOT_ADDR_W-1:0]    boot_araddr,
    output logic                                   boot_arvalid,
    input  logic                                   boot_arready,
    input  logic [soc_mem_pkg::DATA_W-1:0]         boot_rdata,
    input  soc_mem_pkg::axil_resp_e                boot_rresp,
    input  logic                                   boot_rvalid,
    output logic                                   boot_rready,
    output logic [soc_mem_pkg::SYSCTRL_ADDR_W-1:0] sys_awaddr,
    output logic                                   sys_awvalid,
    input  logic                                   sys_awready,
    output logic [soc_mem_pkg::DATA_W-1:0]         sys_wdata,
    output logic [soc_mem_pkg::STRB_W-1:0]         sys_wstrb,
    output logic                                   sys_wvalid,
    input  logic                                   sys_wready,
    input  soc_mem_pkg::axil_resp_e                sys_bresp,
    input  logic                                   sys_bvalid,
    output logic                                   sys_bready,
    output logic [soc_mem_pkg::SYSCTRL_ADDR_W-1:0] sys_araddr,
    output logic                                   sys_arvalid,
    input  logic                                   sys_arready,
    input  logic [soc_mem_pkg::DATA_W-1:0]         sys_rdata,
    input  soc_mem_pkg::axil_resp_e                sys_rresp,
    input  logic                                   sys_rvalid,
    output logic                                   sys_rready
);
    import soc_mem_pkg::*;

    dec_state_e wr_state;
    dec_state_e rd_state;
    target_e wr_tgt;
    target_e rd_tgt;
    target_e wr_dec;
    target_e rd_dec;
    logic [ADDR_W-1:0] awaddr_q;
    logic [BOOT_ADDR_W-1:0] araddr_q;    // Offset only, the region is kept in rd_tgt
    logic [DATA_W-1:0] wdata_q;
    logic [STRB_W-1:0] wstrb_q;
    logic live;
    logic aw_held;
    logic w_held;
    logic aw_sent;
    logic w_sent;
    logic ar_sent;
    logic tgt_bvalid;
    logic tgt_rvalid;

    function automatic target_e decode(input logic [ADDR_W-1:0] addr);
        if (addr[ADDR_W-1:BOOT_ADDR_W] == BOOT_BASE[ADDR_W-1:BOOT_ADDR_W]) begin
            return TGT_BOOT;
        end
        if (addr[ADDR_W-1:SYSCTRL_ADDR_W] == SYSCTRL_BASE[ADDR_W-1:SYSCTRL_ADDR_W]) begin
            return TGT_SYSCTRL;
        end
        return TGT_NONE;
    endfunction

    assign wr_dec = decode(awaddr_q);
    assign rd_dec = decode(s_axil_araddr);

    assign s_axil_awready = live && wr_state == DEC_IDLE && !aw_held;
    assign s_axil_wready = live && wr_state == DEC_IDLE && !w_held;
    assign s_axil_bvalid = wr_state == DEC_RESP;
    assign s_axil_arready = live && rd_state == DEC_IDLE;
    assign s_axil_rvalid = rd_state == DEC_RESP;

    // Forwarded payloads carry only the offset inside the region
    assign boot_awaddr = awaddr_q[BOOT_ADDR_W-1:0];
    assign sys_awaddr = awaddr_q[SYSCTRL_ADDR_W-1:0];
    assign boot_wdata = wdata_q;
    assign sys_wdata = wdata_q;
    assign boot_wstrb = wstrb_q;
    assign sys_wstrb = wstrb_q;
    assign boot_araddr = araddr_q;
    assign sys_araddr = araddr_q[SYSCTRL_ADDR_W-1:0];

    assign boot_awvalid = wr_state == DEC_BUSY && wr_tgt == TGT_BOOT && !aw_sent;
    assign boot_wvalid = wr_state == DEC_BUSY && wr_tgt == TGT_BOOT && !w_sent;
    assign boot_bready = wr_state == DEC_BUSY && wr_tgt == TGT_BOOT;
    assign sys_awvalid = wr_state == DEC_BUSY && wr_tgt == TGT_SYSCTRL && !aw_sent;
    assign sys_wvalid = wr_state == DEC_BUSY && wr_tgt == TGT_SYSCTRL && !w_sent;
    assign sys_bready = wr_state == DEC_BUSY && wr_tgt == TGT_SYSCTRL;
    assign boot_arvalid = rd_state == DEC_BUSY && rd_tgt == TGT_BOOT && !ar_sent;
    assign boot_rready = rd_state == DEC_BUSY && rd_tgt == TGT_BOOT;
    assign sys_arvalid = rd_state == DEC_BUSY && rd_tgt == TGT_SYSCTRL && !ar_sent;
    assign sys_rready = rd_state == DEC_BUSY && rd_tgt == TGT_SYSCTRL;

    assign tgt_bvalid = (wr_tgt == TGT_BOOT) ? boot_bvalid : sys_bvalid;
    assign tgt_rvalid = (rd_tgt == TGT_BOOT) ? boot_rvalid : sys_rvalid;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            live <= 1'b0;
            wr_state <= DEC_IDLE;
            rd_state <= DEC_IDLE;
            aw_held <= 1'b0;
            w_held <= 1'b0;
            aw_sent <= 1'b0;
            w_sent <= 1'b0;
            ar_sent <= 1'b0;
        end else begin
            live <= 1'b1;
            if (s_axil_awvalid && s_axil_awready) begin
                aw_held <= 1'b1;
            end
            if (s_axil_wvalid && s_axil_wready) begin
                w_held <= 1'b1;
            end
            if ((boot_awvalid && boot_awready) || (sys_awvalid && sys_awready)) begin
                aw_sent <= 1'b1;
            end
            if ((boot_wvalid && boot_wready) || (sys_wvalid && sys_wready)) begin
                w_sent <= 1'b1;
            end
            if ((boot_arvalid && boot_arready) || (sys_arvalid && sys_arready)) begin
                ar_sent <= 1'b1;
            end
            case (wr_state)
                DEC_IDLE: begin
                    if (aw_held && w_held) begin
                        wr_state <= (wr_dec == TGT_NONE) ? DEC_RESP : DEC_BUSY;
                    end
                end
                DEC_BUSY: begin
                    if (tgt_bvalid) begin
                        wr_state <= DEC_RESP;
                    end
                end
                default: begin
                    if (s_axil_bready) begin
                        wr_state <= DEC_IDLE;
                        aw_held <= 1'b0;
                        w_held <= 1'b0;
                        aw_sent <= 1'b0;
                        w_sent <= 1'b0;
                    end
                end
            endcase
            case (rd_state)
                DEC_IDLE: begin
                    if (s_axil_arvalid && s_axil_arready) begin
                        rd_state <= (rd_dec == TGT_NONE) ? DEC_RESP : DEC_BUSY;
                    end
                end
                DEC_BUSY: begin
                    if (tgt_rvalid) begin
                        rd_state <= DEC_RESP;
                    end
                end
                default: begin
                    if (s_axil_rready) begin
                        rd_state <= DEC_IDLE;
                        ar_sent <= 1'b0;
                    end
                end
            endcase
        end
    end

    // DECERR and zero data are preset here and replaced by the target's answer when mapped
    always_ff @(posedge aclk) begin
        if (s_axil_awvalid && s_axil_awready) begin
            awaddr_q <= s_axil_awaddr;
        end
        if (s_axil_wvalid && s_axil_wready) begin
            wdata_q <= s_axil_wdata;
            wstrb_q <= s_axil_wstrb;
        end
        if (wr_state == DEC_IDLE && aw_held && w_held) begin
            wr_tgt <= wr_dec;
            s_axil_bresp <= RESP_DECERR;
        end
        if (wr_state == DEC_BUSY && tgt_bvalid) begin
            s_axil_bresp <= (wr_tgt == TGT_BOOT) ? boot_bresp : sys_bresp;
        end
        if (s_axil_arvalid && s_axil_arready) begin
            araddr_q <= s_axil_araddr[BOOT_ADDR_W-1:0];
            rd_tgt <= rd_dec;
            s_axil_rdata <= '0;
            s_axil_rresp <= RESP_DECERR;
        end
        if (rd_state == DEC_BUSY && tgt_rvalid) begin
            s_axil_rdata <= (rd_tgt == TGT_BOOT) ? boot_rdata : sys_rdata;
            s_axil_rresp <= (rd_tgt == TGT_BOOT) ? boot_rresp : sys_rresp;
        end
    end

    // At most one target sees a request on each channel
    assert property (@(posedge aclk) disable iff (!aresetn)
        !((boot_awvalid && sys_awvalid) || (boot_wvalid && sys_wvalid) ||
          (boot_arvalid && sys_arvalid)));

endmodule

// ==== hw/axil_sysctrl_regs.sv ====
// System-control registers: ID, scratch, cycle counter and one reserved word
// Offsets are word aligned; the low two address bits are ignored
`timescale 1ns/1ps

module axil_sysctrl_regs (
    input  logic                                   aclk,
    input  logic                                   aresetn,
    input  logic [soc_mem_pkg::SYSCTRL_ADDR_W-1:0] awaddr,
    input  logic                                   awvalid,
    output logic                                   awready,
    input  logic [soc_mem_pkg::DATA_W-1:0]         wdata,
    input  logic [soc_mem_pkg::STRB_W-1:0]         wstrb,
    input  logic                                   wvalid,
    output logic                                   wready,
    output soc_mem_pkg::axil_resp_e                bresp,
    output logic                                   bvalid,
    input  logic                                   bready,
    input  logic [soc_mem_pkg::SYSCTRL_ADDR_W-1:0] araddr,
    input  logic                                   arvalid,
    output logic                                   arready,
    output logic [soc_mem_pkg::DATA_W-1:0]         rdata,
    output soc_mem_pkg::axil_resp_e                rresp,
    output logic                                   rvalid,
    input  logic                                   rready
);
    import soc_mem_pkg::*;

    logic [SYSCTRL_ADDR_W-1:0] aw_addr_q;
    logic [DATA_W-1:0] w_data_q;
    logic [STRB_W-1:0] w_strb_q;
    logic [DATA_W-1:0] scratch;
    logic [DATA_W-1:0] cycle_cnt;
    logic aw_held;
    logic w_held;
    logic live;
    logic do_write;

    assign awready = live && !aw_held;
    assign wready = live && !w_held;
    assign arready = live && !rvalid;
    assign rresp = RESP_OKAY;
    assign do_write = aw_held && w_held && !bvalid;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            live <= 1'b0;
            aw_held <= 1'b0;
            w_held <= 1'b0;
            bvalid <= 1'b0;
            rvalid <= 1'b0;
            scratch <= '0;
            cycle_cnt <= '0;
        end else begin
            live <= 1'b1;
            cycle_cnt <= cycle_cnt + 1'b1;    // Free running, wraps silently
            if (awvalid && awready) begin
                aw_held <= 1'b1;
            end
            if (wvalid && wready) begin
                w_held <= 1'b1;
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
                aw_held <= 1'b0;
                w_held <= 1'b0;
            end else if (do_write) begin
                bvalid <= 1'b1;
            end
            // Only the scratch word takes write data
            if (do_write && aw_addr_q[SYSCTRL_ADDR_W-1:2] == 2'd1) begin
                for (int b = 0; b < STRB_W; b++) begin
                    if (w_strb_q[b]) begin
                        scratch[8*b +: 8] <= w_data_q[8*b +: 8];
                    end
                end
            end
            if (arvalid && arready) begin
                rvalid <= 1'b1;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (awvalid && awready) begin
            aw_addr_q <= awaddr;
        end
        if (wvalid && wready) begin
            w_data_q <= wdata;
            w_strb_q <= wstrb;
        end
        if (do_write) begin
            bresp <= (aw_addr_q[SYSCTRL_ADDR_W-1:2] == 2'd0) ? RESP_SLVERR : RESP_OKAY;
        end
        if (arvalid && arready) begin
            case (araddr[SYSCTRL_ADDR_W-1:2])
                2'd0: rdata <= SYSCTRL_ID;
                2'd1: rdata <= scratch;
                2'd2: rdata <= cycle_cnt;
                default: rdata <= '0;         // Reserved word
            endcase
        end
    end

endmodule

// ==== hw/soc_mem_top.sv ====
// Memory subsystem top: address decoder in front of the boot memory and the registers
// The master port is AXI-Lite without protection signals or bursts
`timescale 1ns/1ps

module soc_mem_top (
    input  logic                           aclk,
    input  logic                           aresetn,
    input  logic [soc_mem_pkg::ADDR_W-1:0] s_axil_awaddr,
    input  logic                           s_axil_awvalid,
    output logic                           s_axil_awready,
    input  logic [soc_mem_pkg::DATA_W-1:0] s_axil_wdata,
    input  logic [soc_mem_pkg::STRB_W-1:0] s_axil_wstrb,
    input  logic                           s_axil_wvalid,
    output logic                           s_axil_wready,
    output soc_mem_pkg::axil_resp_e        s_axil_bresp,
    output logic                           s_axil_bvalid,
    input  logic                           s_axil_bready,
    input  logic [soc_mem_pkg::ADDR_W-1:0] s_axil_araddr,
    input  logic                           s_axil_arvalid,
    output logic                           s_axil_arready,
    output logic [soc_mem_pkg::DATA_W-1:0] s_axil_rdata,
    output soc_mem_pkg::axil_resp_e        s_axil_rresp,
    output logic                           s_axil_rvalid,
    input  logic                           s_axil_rready
);
    import soc_mem_pkg::*;

    logic [BOOT_ADDR_W-1:0] boot_awaddr;
    logic boot_awvalid;
    logic boot_awready;
    logic [DATA_W-1:0] boot_wdata;
    logic [STRB_W-1:0] boot_wstrb;
    logic boot_wvalid;
    logic boot_wready;
    axil_resp_e boot_bresp;
    logic boot_bvalid;
    logic boot_bready;
    logic [BOOT_ADDR_W-1:0] boot_araddr;
    logic boot_arvalid;
    logic boot_arready;
    logic [DATA_W-1:0] boot_rdata;
    axil_resp_e boot_rresp;
    logic boot_rvalid;
    logic boot_rready;

    logic [SYSCTRL_ADDR_W-1:0] sys_awaddr;
    logic sys_awvalid;
    logic sys_awready;
    logic [DATA_W-1:0] sys_wdata;
    logic [STRB_W-1:0] sys_wstrb;
    logic sys_wvalid;
    logic sys_wready;
    axil_resp_e sys_bresp;
    logic sys_bvalid;
    logic sys_bready;
    logic [SYSCTRL_ADDR_W-1:0] sys_araddr;
    logic sys_arvalid;
    logic sys_arready;
    logic [DATA_W-1:0] sys_rdata;
    axil_resp_e sys_rresp;
    logic sys_rvalid;
    logic sys_rready;

    // Every decoder port name matches a port or wire here
    axil_addr_decoder u_decoder (.*);

    axil_boot_mem u_boot_mem (
        .aclk    (aclk),
        .aresetn (aresetn),
        .awaddr  (boot_awaddr),
        .awvalid (boot_awvalid),
        .awready (boot_awready),
        .wdata   (boot_wdata),
        .wstrb   (boot_wstrb),
        .wvalid  (boot_wvalid),
        .wready  (boot_wready),
        .bresp   (boot_bresp),
        .bvalid  (boot_bvalid),
        .bready  (boot_bready),
        .araddr  (boot_araddr),
        .arvalid (boot_arvalid),
        .arready (boot_arready),
        .rdata   (boot_rdata),
        .rresp   (boot_rresp),
        .rvalid  (boot_rvalid),
        .rready  (boot_rready)
    );

    axil_sysctrl_regs u_sysctrl (
        .aclk    (aclk),
        .aresetn (aresetn),
        .awaddr  (sys_awaddr),
        .awvalid (sys_awvalid),
        .awready (sys_awready),
        .wdata   (sys_wdata),
        .wstrb   (sys_wstrb),
        .wvalid  (sys_wvalid),
        .wready  (sys_wready),
        .bresp   (sys_bresp),
        .bvalid  (sys_bvalid),
        .bready  (sys_bready),
        .araddr  (sys_araddr),
        .arvalid (sys_arvalid),
        .arready (sys_arready),
        .rdata   (sys_rdata),
        .rresp   (sys_rresp),
        .rvalid  (sys_rvalid),
        .rready  (sys_rready)
    );

endmodule

// ==== verif/soc_mem_tb.sv ====
// Table-driven testbench for the memory subsystem, one transaction at a time
// Needs the boot image at hw/boot_image.hex, so run from the project root
`timescale 1ns/1ps

module soc_mem_tb;
    import soc_mem_pkg::*;

    typedef enum logic {OP_READ, OP_WRITE} op_e;

    typedef struct {
        op_e op;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic [STRB_W-1:0] strb;
        logic [DATA_W-1:0] exp_data;
        axil_resp_e exp_resp;
        logic gt;                          // Read must exceed the previous read instead
    } entry_t;

    localparam int N_ENTRIES = 28;
    localparam int TIMEOUT_CYCLES = 40 * N_ENTRIES + 20;

    logic aclk;
    logic aresetn;
    logic [ADDR_W-1:0] s_axil_awaddr;
    logic s_axil_awvalid;
    logic s_axil_awready;
    logic [DATA_W-1:0] s_axil_wdata;
    logic [STRB_W-1:0] s_axil_wstrb;
    logic s_axil_wvalid;
    logic s_axil_wready;
    axil_resp_e s_axil_bresp;
    logic s_axil_bvalid;
    logic s_axil_bready;
    logic [ADDR_W-1:0] s_axil_araddr;
    logic s_axil_arvalid;
    logic s_axil_arready;
    logic [DATA_W-1:0] s_axil_rdata;
    axil_resp_e s_axil_rresp;
    logic s_axil_rvalid;
    logic s_axil_rready;

    entry_t tests [N_ENTRIES];
    int n_filled = 0;
    int cycles = 0;
    int b_count = 0;
    int r_count = 0;
    logic b_wait = 1'b0;                   // The same B response is still on show after a stall
    logic r_wait = 1'b0;
    logic [31:0] lfsr_state = 32'h8393_24f2;

    soc_mem_top UUT (.*);

    initial begin
        aclk = 1'b0;
        forever #50 aclk = ~aclk;
    end

    // Each response is counted once, in the first cycle it shows on the master port
    always @(posedge aclk) begin
        cycles <= cycles + 1;
        if (aresetn && s_axil_bvalid && !b_wait) b_count <= b_count + 1;
        if (aresetn && s_axil_rvalid && !r_wait) r_count <= r_count + 1;
        b_wait <= aresetn && s_axil_bvalid && !s_axil_bready;
        r_wait <= aresetn && s_axil_rvalid && !s_axil_rready;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("The run timed out after %0d cycles without finishing", cycles);
            $display("Done: errors found");
            $fatal(1, "Simulation timed out");
        end
    end

    function automatic logic [31:0] image_word(input int idx);
        return {16'hB007, idx[15:0]};
    endfunction

    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %0t ns: %s: got 32'h%08h, expected 32'h%08h",
                     $time, what, actual, expected);
            $display("Done: errors found");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    // Galois form, right shifting, one step per bit taken
    task automatic draw_ready_delay(output int unsigned delay);
        delay = 0;
        for (int b = 0; b < 3; b++) begin
            delay = {delay, lfsr_state[0]};
            lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
        end
    endtask

    task automatic add_read(input logic [31:0] addr, input logic [31:0] exp_data,
                            input axil_resp_e exp_resp, input logic gt);
        tests[n_filled] = '{OP_READ, addr, 32'h0, 4'h0, exp_data, exp_resp, gt};
        n_filled++;
    endtask

    task automatic add_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input axil_resp_e exp_resp);
        tests[n_filled] = '{OP_WRITE, addr, data, strb, 32'h0, exp_resp, 1'b0};
        n_filled++;
    endtask

    // All sampling happens right after a rising edge, so the values are the ones the DUT saw
    task automatic do_write(input entry_t e, output axil_resp_e resp);
        bit aw_done;
        bit w_done;
        int unsigned delay;
        axil_resp_e first_resp;
        aw_done = 0;
        w_done = 0;
        s_axil_awaddr <= e.addr;
        s_axil_awvalid <= 1'b1;
        s_axil_wdata <= e.wdata;
        s_axil_wstrb <= e.strb;
        s_axil_wvalid <= 1'b1;
        while (!(aw_done && w_done)) begin
            @(posedge aclk);
            if (!aw_done && s_axil_awready) begin
                aw_done = 1;
                s_axil_awvalid <= 1'b0;
            end
            if (!w_done && s_axil_wready) begin
                w_done = 1;
                s_axil_wvalid <= 1'b0;
            end
        end
        draw_ready_delay(delay);
        while (!s_axil_bvalid) @(posedge aclk);
        first_resp = s_axil_bresp;
        repeat (delay) @(posedge aclk);
        s_axil_bready <= 1'b1;
        @(posedge aclk);
        check_value("bvalid held under back-pressure", s_axil_bvalid, 1'b1);
        check_value("bresp stable under back-pressure", s_axil_bresp, first_resp);
        resp = s_axil_bresp;
        s_axil_bready <= 1'b0;
    endtask

    task automatic do_read(input entry_t e, output logic [31:0] data, output axil_resp_e resp);
        int unsigned delay;
        logic [31:0] first_data;
        s_axil_araddr <= e.addr;
        s_axil_arvalid <= 1'b1;
        do @(posedge aclk); while (!s_axil_arready);
        s_axil_arvalid <= 1'b0;
        draw_ready_delay(delay);
        while (!s_axil_rvalid) @(posedge aclk);
        first_data = s_axil_rdata;
        repeat (delay) @(posedge aclk);
        s_axil_rready <= 1'b1;
        @(posedge aclk);
        check_value("rvalid held under back-pressure", s_axil_rvalid, 1'b1);
        check_value("rdata stable under back-pressure", s_axil_rdata, first_data);
        data = s_axil_rdata;
        resp = s_axil_rresp;
        s_axil_rready <= 1'b0;
    endtask

    initial begin
        logic [31:0] rd_data;
        logic [31:0] prev_data;
        axil_resp_e resp;
        int n_writes;
        int n_reads;
        aresetn = 1'b0;
        s_axil_awaddr = '0;
        s_axil_awvalid = 1'b0;
        s_axil_wdata = '0;
        s_axil_wstrb = '0;
        s_axil_wvalid = 1'b0;
        s_axil_bready = 1'b0;
        s_axil_araddr = '0;
        s_axil_arvalid = 1'b0;
        s_axil_rready = 1'b0;
        prev_data = '0;
        n_writes = 0;
        n_reads = 0;

        add_read(32'h0000_0000, image_word(0), RESP_OKAY, 1'b0);
        add_read(32'h0000_0004, image_word(1), RESP_OKAY, 1'b0);
        add_read(32'h0000_0044, image_word(17), RESP_OKAY, 1'b0);
        add_read(32'h0000_007C, image_word(31), RESP_OKAY, 1'b0);
        add_write(32'h0000_0100, 32'h1122_3344, 4'b1111, RESP_OKAY);
        add_read(32'h0000_0100, 32'h1122_3344, RESP_OKAY, 1'b0);
        add_write(32'h0000_0100, 32'hAABB_CCDD, 4'b0101, RESP_OKAY);
        add_read(32'h0000_0100, 32'h11BB_33DD, RESP_OKAY, 1'b0);
        add_write(32'h0000_0100, 32'hEE00_0000, 4'b1000, RESP_OKAY);
        add_read(32'h0000_0100, 32'hEEBB_33DD, RESP_OKAY, 1'b0);
        add_read(32'h0000_0101, 32'h00EE_BB33, RESP_OKAY, 1'b0);
        add_read(32'h0000_0102, 32'h0000_EEBB, RESP_OKAY, 1'b0);
        add_read(32'h0000_0103, 32'h0000_00EE, RESP_OKAY, 1'b0);
        add_read(32'h0000_0015, image_word(5) >> 8, RESP_OKAY, 1'b0);
        add_read(32'h1000_0000, SYSCTRL_ID, RESP_OKAY, 1'b0);
        add_write(32'h1000_0000, 32'hFFFF_FFFF, 4'b1111, RESP_SLVERR);
        add_read(32'h1000_0000, SYSCTRL_ID, RESP_OKAY, 1'b0);
        add_write(32'h1000_0004, 32'h1234_5678, 4'b1111, RESP_OKAY);
        add_read(32'h1000_0004, 32'h1234_5678, RESP_OKAY, 1'b0);
        add_write(32'h1000_0004, 32'h9ABC_DEF0, 4'b0010, RESP_OKAY);
        add_read(32'h1000_0004, 32'h1234_DE78, RESP_OKAY, 1'b0);
        add_write(32'h1000_0008, 32'hFFFF_FFFF, 4'b1111, RESP_OKAY);
        add_read(32'h1000_000C, 32'h0000_0000, RESP_OKAY, 1'b0);  // Zero ahead of the counter
        add_read(32'h1000_0008, 32'h0, RESP_OKAY, 1'b1);
        add_read(32'h1000_0008, 32'h0, RESP_OKAY, 1'b1);
        add_read(32'h2000_0000, 32'h0000_0000, RESP_DECERR, 1'b0);
        add_write(32'h2000_0000, 32'h5555_AAAA, 4'b1111, RESP_DECERR);
        add_read(32'h0000_0000, image_word(0), RESP_OKAY, 1'b0);    // No alias of word 0
        check_value("table entries filled", n_filled, N_ENTRIES);

        repeat (10) @(posedge aclk);
        aresetn <= 1'b1;
        @(posedge aclk);

        for (int i = 0; i < N_ENTRIES; i++) begin
            if (tests[i].op == OP_WRITE) begin
                do_write(tests[i], resp);
                n_writes++;
                check_value($sformatf("entry %0d bresp", i), resp, tests[i].exp_resp);
            end else begin
                do_read(tests[i], rd_data, resp);
                n_reads++;
                check_value($sformatf("entry %0d rresp", i), resp, tests[i].exp_resp);
                if (tests[i].gt) begin
                    check_value($sformatf("entry %0d counter increases", i),
                                rd_data > prev_data, 1'b1);
                end else begin
                    check_value($sformatf("entry %0d rdata", i), rd_data, tests[i].exp_data);
                end
                prev_data = rd_data;
            end
            @(posedge aclk);
            check_value("no repeated bvalid", s_axil_bvalid, 1'b0);
            check_value("no repeated rvalid", s_axil_rvalid, 1'b0);
            check_value("write response count", b_count, n_writes);
            check_value("read response count", r_count, n_reads);
        end

        repeat (5) @(posedge aclk);
        check_value("final write response count", b_count, n_writes);
        check_value("final read response count", r_count, n_reads);
        $display("Done: no errors");
        $finish;
    end

endmodule

// ==== soc_mem.f ====
hw/soc_mem_pkg.sv
hw/axil_boot_mem.sv
hw/axil_addr_decoder.sv
hw/axil_sysctrl_regs.sv
hw/soc_mem_top.sv
verif/soc_mem_tb.sv

// ==== hw/boot_image.hex ====
// One 32-bit word per line: upper half B007, lower half the word index
B0070000
B0070001
B0070002
B0070003
B0070004
B0070005
B0070006
B0070007
B0070008
B0070009
B007000A
B007000B
B007000C
B007000D
B007000E
B007000F
B0070010
B0070011
B0070012
B0070013
B0070014
B0070015
B0070016
B0070017
B0070018
B0070019
B007001A
B007001B
B007001C
B007001D
B007001E
B007001F
